//--- verilog/aes_pkg.sv
`default_nettype none

package aes_pkg;

  typedef logic [7:0]   byte_t;
  typedef logic [127:0] block_t;  // byte 0 in the top bits
  typedef logic [31:0]  word_t;
  typedef logic [3:0]   round_t;
  typedef logic [4:0]   step_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADD_KEY,
    ST_SUB_BYTES,
    ST_SUB_WORD,
    ST_MIX
  } aes_phase_e;

  localparam int unsigned NUM_ROUNDS  = 10;
  localparam int unsigned BLOCK_BYTES = 16;
  localparam int unsigned WORD_BYTES  = 4;
  localparam byte_t       GF_POLY     = 8'h1b;

  function automatic byte_t xtime(byte_t b);
    return b[7] ? ({b[6:0], 1'b0} ^ GF_POLY) : {b[6:0], 1'b0};
  endfunction

  function automatic byte_t mul3(byte_t b);
    return xtime(b) ^ b;
  endfunction

  // powers of two wrap past 8'h80
  function automatic byte_t rcon_of(round_t r);
    byte_t rc;
    case (r)
      4'd9:    rc = 8'h1b;
      4'd10:   rc = 8'h36;
      default: rc = (r != 4'd0 && r <= 4'd8) ? (8'h01 << (r - 4'd1)) : 8'h00;
    endcase
    return rc;
  endfunction

endpackage

`default_nettype wire

//--- verilog/aes_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface aes_ctrl_if;

  aes_pkg::aes_phase_e phase;
  aes_pkg::round_t     round;
  aes_pkg::step_t      step;
  logic                lookup_last;  // final step of a lookup phase
  logic                round_last;

  modport fsm (
    output phase,
    input  lookup_last, round_last
  );

  modport cnt (
    output round, step, lookup_last, round_last,
    input  phase
  );

  modport data (
    input phase, round, step, lookup_last, round_last
  );

endinterface

`default_nettype wire

//--- verilog/aes_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module aes_ctrl_fsm (
  input  logic    clk,
  input  logic    rst,
  input  logic    start_i,
  aes_ctrl_if.fsm ctrl,
  output logic    load_o,
  output logic    done_o
);

  aes_pkg::aes_phase_e phase_q;
  aes_pkg::aes_phase_e phase_d;

  assign ctrl.phase = phase_q;
  assign load_o     = (phase_q == aes_pkg::ST_IDLE) && start_i;  // capture strobe

  always_comb begin
    phase_d = phase_q;
    case (phase_q)
      aes_pkg::ST_IDLE: begin
        if (start_i) phase_d = aes_pkg::ST_ADD_KEY;
      end
      aes_pkg::ST_ADD_KEY: begin
        phase_d = ctrl.round_last ? aes_pkg::ST_IDLE : aes_pkg::ST_SUB_BYTES;
      end
      aes_pkg::ST_SUB_BYTES: begin
        if (ctrl.lookup_last) phase_d = aes_pkg::ST_SUB_WORD;
      end
      aes_pkg::ST_SUB_WORD: begin
        // no mix columns in the final round
        if (ctrl.lookup_last) begin
          phase_d = ctrl.round_last ? aes_pkg::ST_ADD_KEY : aes_pkg::ST_MIX;
        end
      end
      aes_pkg::ST_MIX: phase_d = aes_pkg::ST_ADD_KEY;
      default: phase_d = aes_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase_q <= aes_pkg::ST_IDLE;
      done_o  <= 1'b0;
    end else begin
      phase_q <= phase_d;
      done_o  <= (phase_q == aes_pkg::ST_ADD_KEY) && ctrl.round_last;
    end
  end

  a_done_after_add_key : assert property (@(posedge clk) disable iff (rst)
    done_o |-> $past(phase_q) == aes_pkg::ST_ADD_KEY &&
               $past(phase_q, 2) == aes_pkg::ST_SUB_WORD)
    else $error("done without the final key word lookup and add round key");

  a_idle_needs_start : assert property (@(posedge clk) disable iff (rst)
    (phase_q == aes_pkg::ST_IDLE && !start_i) |=> phase_q == aes_pkg::ST_IDLE)
    else $error("left idle without start");

endmodule

`default_nettype wire

//--- verilog/aes_step_counter.sv
`timescale 1ns/1ps
`default_nettype none

module aes_step_counter #(
  parameter int unsigned ROM_LATENCY = 1
) (
  input  logic    clk,
  input  logic    rst,
  aes_ctrl_if.cnt ctrl
);

  // last step index of each lookup phase
  localparam aes_pkg::step_t BYTES_LAST =
    aes_pkg::step_t'(aes_pkg::BLOCK_BYTES + ROM_LATENCY);
  localparam aes_pkg::step_t WORD_LAST =
    aes_pkg::step_t'(aes_pkg::WORD_BYTES + ROM_LATENCY);

  aes_pkg::step_t  step_q;
  aes_pkg::round_t round_q;
  logic            in_lookup;

  assign in_lookup = (ctrl.phase == aes_pkg::ST_SUB_BYTES) ||
                     (ctrl.phase == aes_pkg::ST_SUB_WORD);

  assign ctrl.step        = step_q;
  assign ctrl.round       = round_q;
  assign ctrl.lookup_last = (ctrl.phase == aes_pkg::ST_SUB_BYTES && step_q == BYTES_LAST) ||
                            (ctrl.phase == aes_pkg::ST_SUB_WORD && step_q == WORD_LAST);
  assign ctrl.round_last  = (round_q == aes_pkg::round_t'(aes_pkg::NUM_ROUNDS));

  always_ff @(posedge clk) begin
    if (rst) begin
      step_q  <= '0;
      round_q <= '0;
    end else begin
      if (!in_lookup || ctrl.lookup_last) step_q <= '0;  // next phase starts at 0
      else step_q <= step_q + 1'b1;
      if (ctrl.phase == aes_pkg::ST_IDLE) round_q <= '0;
      else if (ctrl.phase == aes_pkg::ST_ADD_KEY) round_q <= round_q + 1'b1;
    end
  end

  a_step_bound : assert property (@(posedge clk) disable iff (rst)
    in_lookup |->
      step_q <= (ctrl.phase == aes_pkg::ST_SUB_BYTES ? BYTES_LAST : WORD_LAST))
    else $error("lookup step ran past its phase length");

endmodule

`default_nettype wire

//--- verilog/aes_sbox_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module aes_sbox_lookup #(
  parameter int unsigned ROM_LATENCY = 1
) (
  input  logic            clk,
  input  logic            rst,
  aes_ctrl_if.data        ctrl,
  input  aes_pkg::block_t state_block_i,
  input  aes_pkg::word_t  key_word_i,
  input  aes_pkg::byte_t  rom_data_i,
  output aes_pkg::byte_t  rom_addr_o,
  output aes_pkg::block_t sub_block_o,
  output aes_pkg::word_t  sub_word_o
);

  // address register plus rom delay
  localparam aes_pkg::step_t CAP_OFS = aes_pkg::step_t'(ROM_LATENCY + 1);

  aes_pkg::word_t  rot_word;
  aes_pkg::step_t  cap_idx;
  logic            cap_valid;
  aes_pkg::block_t blk_q;
  aes_pkg::word_t  wrd_q;

  assign rot_word  = {key_word_i[23:0], key_word_i[31:24]};  // RotWord
  assign cap_valid = (ctrl.step >= CAP_OFS);
  assign cap_idx   = ctrl.step - CAP_OFS;

  always_ff @(posedge clk) begin
    if (rst) begin
      rom_addr_o <= '0;
    end else if (ctrl.phase == aes_pkg::ST_SUB_BYTES && ctrl.step < aes_pkg::BLOCK_BYTES) begin
      rom_addr_o <= state_block_i[8*(aes_pkg::BLOCK_BYTES-1-ctrl.step) +: 8];
    end else if (ctrl.phase == aes_pkg::ST_SUB_WORD && ctrl.step < aes_pkg::WORD_BYTES) begin
      rom_addr_o <= rot_word[8*(aes_pkg::WORD_BYTES-1-ctrl.step) +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (cap_valid && ctrl.phase == aes_pkg::ST_SUB_BYTES) begin
      blk_q[8*(aes_pkg::BLOCK_BYTES-1-cap_idx) +: 8] <= rom_data_i;
    end
    if (cap_valid && ctrl.phase == aes_pkg::ST_SUB_WORD) begin
      wrd_q[8*(aes_pkg::WORD_BYTES-1-cap_idx) +: 8] <= rom_data_i;
    end
  end

  // last byte is still on the rom bus when the phase ends
  always_comb begin
    sub_block_o = blk_q;
    sub_word_o  = wrd_q;
    if (ctrl.lookup_last && ctrl.phase == aes_pkg::ST_SUB_BYTES) sub_block_o[7:0] = rom_data_i;
    if (ctrl.lookup_last && ctrl.phase == aes_pkg::ST_SUB_WORD) sub_word_o[7:0] = rom_data_i;
  end

  a_addr_in_lookup : assert property (@(posedge clk) disable iff (rst)
    (!$past(rst) && !$stable(rom_addr_o)) |->
      $past(ctrl.phase) inside {aes_pkg::ST_SUB_BYTES, aes_pkg::ST_SUB_WORD})
    else $error("rom address moved outside a lookup phase");

endmodule

`default_nettype wire

//--- verilog/aes_key_expand.sv
`timescale 1ns/1ps
`default_nettype none

module aes_key_expand (
  input  logic            clk,
  input  logic            rst,
  aes_ctrl_if.data        ctrl,
  input  logic            load_i,
  input  aes_pkg::block_t key_i,
  input  aes_pkg::word_t  sub_word_i,
  output aes_pkg::word_t  key_word_o,
  output aes_pkg::block_t round_key_o
);

  aes_pkg::block_t key_q;
  aes_pkg::block_t next_key;

  assign key_word_o  = key_q[31:0];  // w3 feeds the next SubWord
  assign round_key_o = key_q;

  // each new word chains off the one before it
  always_comb begin
    aes_pkg::word_t acc;
    acc = sub_word_i ^ {aes_pkg::rcon_of(ctrl.round), 24'h000000};
    for (int i = 0; i < aes_pkg::WORD_BYTES; i++) begin
      acc = acc ^ key_q[32*(aes_pkg::WORD_BYTES-1-i) +: 32];
      next_key[32*(aes_pkg::WORD_BYTES-1-i) +: 32] = acc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      key_q <= '0;
    end else if (load_i) begin
      key_q <= key_i;
    end else if (ctrl.phase == aes_pkg::ST_SUB_WORD && ctrl.lookup_last) begin
      key_q <= next_key;  // round key for the coming add
    end
  end

endmodule

`default_nettype wire

//--- verilog/aes_state_path.sv
`timescale 1ns/1ps
`default_nettype none

module aes_state_path (
  input  logic            clk,
  input  logic            rst,
  aes_ctrl_if.data        ctrl,
  input  logic            load_i,
  input  aes_pkg::block_t plaintext_i,
  input  aes_pkg::block_t round_key_i,
  input  aes_pkg::block_t sub_block_i,
  output aes_pkg::block_t state_o
);

  aes_pkg::block_t pt_q;
  aes_pkg::block_t state_q;
  aes_pkg::block_t shifted;
  aes_pkg::block_t mixed;

  function automatic aes_pkg::byte_t byte_at(aes_pkg::block_t b, int unsigned idx);
    return b[8*(aes_pkg::BLOCK_BYTES-1-idx) +: 8];
  endfunction

  assign state_o = state_q;

  // byte index is 4*col + row, row r rotates left by r columns
  always_comb begin
    for (int c = 0; c < aes_pkg::WORD_BYTES; c++) begin
      for (int r = 0; r < aes_pkg::WORD_BYTES; r++) begin
        shifted[8*(aes_pkg::BLOCK_BYTES-1-(4*c+r)) +: 8] =
          byte_at(sub_block_i, 4*((c+r)%4) + r);
      end
    end
  end

  // circulant 2 3 1 1 per column
  always_comb begin
    for (int c = 0; c < aes_pkg::WORD_BYTES; c++) begin
      for (int r = 0; r < aes_pkg::WORD_BYTES; r++) begin
        mixed[8*(aes_pkg::BLOCK_BYTES-1-(4*c+r)) +: 8] =
          aes_pkg::xtime(byte_at(state_q, 4*c + r)) ^
          aes_pkg::mul3(byte_at(state_q, 4*c + (r+1)%4)) ^
          byte_at(state_q, 4*c + (r+2)%4) ^
          byte_at(state_q, 4*c + (r+3)%4);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_i) pt_q <= plaintext_i;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= '0;
    end else begin
      case (ctrl.phase)
        aes_pkg::ST_ADD_KEY: begin
          // round 0 starts from the captured plaintext
          state_q <= (ctrl.round == '0 ? pt_q : state_q) ^ round_key_i;
        end
        aes_pkg::ST_SUB_BYTES: begin
          if (ctrl.lookup_last) state_q <= shifted;
        end
        aes_pkg::ST_MIX: state_q <= mixed;
        default: state_q <= state_q;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/aes_core.sv
`timescale 1ns/1ps
`default_nettype none

module aes_core #(
  parameter int unsigned ROM_LATENCY = 1
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            start_i,
  input  aes_pkg::block_t plaintext_i,
  input  aes_pkg::block_t key_i,
  input  aes_pkg::byte_t  rom_data_i,
  output aes_pkg::byte_t  rom_addr_o,
  output aes_pkg::block_t ciphertext_o,
  output logic            done_o
);

  aes_ctrl_if ctrl ();

  logic            load;
  aes_pkg::block_t state_blk;
  aes_pkg::block_t sub_block;
  aes_pkg::block_t round_key;
  aes_pkg::word_t  sub_word;
  aes_pkg::word_t  key_word;

  assign ciphertext_o = state_blk;  // state after the last add is the result

  aes_ctrl_fsm fsm0 (
    .clk(clk), .rst(rst), .start_i(start_i), .ctrl(ctrl.fsm), .load_o(load), .done_o(done_o)
  );

  aes_step_counter #(.ROM_LATENCY(ROM_LATENCY)) cnt0 (
    .clk(clk), .rst(rst), .ctrl(ctrl.cnt)
  );

  aes_sbox_lookup #(.ROM_LATENCY(ROM_LATENCY)) sbox0 (
    .clk(clk), .rst(rst), .ctrl(ctrl.data),
    .state_block_i(state_blk), .key_word_i(key_word),
    .rom_data_i(rom_data_i), .rom_addr_o(rom_addr_o),
    .sub_block_o(sub_block), .sub_word_o(sub_word)
  );

  aes_key_expand key0 (
    .clk(clk), .rst(rst), .ctrl(ctrl.data), .load_i(load), .key_i(key_i),
    .sub_word_i(sub_word), .key_word_o(key_word), .round_key_o(round_key)
  );

  aes_state_path state0 (
    .clk(clk), .rst(rst), .ctrl(ctrl.data), .load_i(load), .plaintext_i(plaintext_i),
    .round_key_i(round_key), .sub_block_i(sub_block), .state_o(state_blk)
  );

endmodule

`default_nettype wire

//--- sim/aes_model.svh
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

logic [7:0] sbox_tab [0:255];

// shift and add, reduced by x^8 + x^4 + x^3 + x + 1
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] p;
  p = 8'h00;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) p = p ^ a;
    a = a[7] ? ({a[6:0], 1'b0} ^ 8'h1b) : {a[6:0], 1'b0};
  end
  return p;
endfunction

function automatic logic [7:0] gf_inv(input logic [7:0] a);
  logic [7:0] r;
  r = 8'h00;  // zero has no inverse, maps to zero
  for (int i = 1; i < 256; i++) begin
    if (gf_mul(a, i[7:0]) == 8'h01) r = i[7:0];
  end
  return r;
endfunction

function automatic logic [7:0] sbox_calc(input logic [7:0] a);
  logic [7:0] b;
  b = gf_inv(a);
  return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]} ^ {b[3:0], b[7:4]} ^ 8'h63;
endfunction

task automatic fill_sbox();
  for (int i = 0; i < 256; i++) begin
    sbox_tab[i] = sbox_calc(i[7:0]);
  end
endtask

// x^16 + x^14 + x^13 + x^11 + 1, new bit enters at bit 0
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [127:0] encrypt_block(input logic [127:0] pt, input logic [127:0] key);
  logic [43:0][31:0] w;
  logic [15:0][7:0]  s;
  logic [15:0][7:0]  t;
  logic [31:0]       tmp;
  logic [7:0]        rc;
  logic [7:0]        acc;
  logic [7:0]        coef;
  logic [127:0]      ct;
  rc = 8'h01;
  for (int i = 0; i < 4; i++) w[i] = key[127-32*i -: 32];
  for (int i = 4; i < 44; i++) begin
    tmp = w[i-1];
    if (i % 4 == 0) begin
      tmp = {sbox_tab[tmp[23:16]], sbox_tab[tmp[15:8]], sbox_tab[tmp[7:0]],
             sbox_tab[tmp[31:24]]} ^ {rc, 24'h000000};  // rot, sub, rcon
      rc = gf_mul(rc, 8'h02);
    end
    w[i] = w[i-4] ^ tmp;
  end
  for (int i = 0; i < 16; i++) s[i] = pt[127-8*i -: 8] ^ w[i/4][31-8*(i%4) -: 8];
  for (int r = 1; r <= 10; r++) begin
    for (int i = 0; i < 16; i++) begin
      t[i] = sbox_tab[s[4*((i/4 + i%4) % 4) + i%4]];  // row i%4 moves left
    end
    s = t;
    if (r < 10) begin
      for (int i = 0; i < 16; i++) begin
        acc = 8'h00;
        for (int k = 0; k < 4; k++) begin
          case ((k - i%4 + 4) % 4)
            0:       coef = 8'h02;
            1:       coef = 8'h03;
            default: coef = 8'h01;
          endcase
          acc = acc ^ gf_mul(t[4*(i/4) + k], coef);
        end
        s[i] = acc;
      end
    end
    for (int i = 0; i < 16; i++) s[i] = s[i] ^ w[4*r + i/4][31-8*(i%4) -: 8];
  end
  for (int i = 0; i < 16; i++) ct[127-8*i -: 8] = s[i];
  return ct;
endfunction

`endif

//--- sim/tb_aes_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_aes_core;

  logic         clk;
  logic         rst;
  logic         start;
  logic [127:0] plaintext;
  logic [127:0] key;
  logic [7:0]   rom_data;
  logic [7:0]   rom_addr;
  logic [127:0] ciphertext;
  logic         done;
  logic [15:0]  lfsr_state;

  `include "aes_model.svh"

  aes_core #(.ROM_LATENCY(1)) dut0 (
    .clk(clk), .rst(rst), .start_i(start), .plaintext_i(plaintext), .key_i(key),
    .rom_data_i(rom_data), .rom_addr_o(rom_addr), .ciphertext_o(ciphertext), .done_o(done)
  );

  always #50 clk = ~clk;

  always @(posedge clk) rom_data <= sbox_tab[rom_addr];  // one cycle rom

  task automatic abort_run();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (actual !== expected) begin
      $display("Error %s: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic random_block(output logic [127:0] v);
    for (int i = 0; i < 128; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[126:0], lfsr_state[0]};
    end
  endtask

  task automatic start_block(input logic [127:0] pt, input logic [127:0] k);
    plaintext = pt;
    key       = k;
    start     = 1'b1;
    next_cycle();
    start     = 1'b0;
  endtask

  task automatic wait_done(input string name);
    int n;
    n = 0;
    while (!done && n < 400) begin
      next_cycle();
      n++;
    end
    if (!done) begin
      $display("%s: done never asserted within 400 cycles", name);
      abort_run();
    end
  endtask

  // one block with its result and its done pulse checked
  task automatic run_block(input string name, input logic [127:0] pt, input logic [127:0] k);
    start_block(pt, k);
    wait_done(name);
    check_value(name, encrypt_block(pt, k), ciphertext);
    next_cycle();
    check_value({name, " done pulse"}, 128'd0, {127'd0, done});
  endtask

  initial begin
    logic [127:0] pt;
    logic [127:0] k;
    logic [127:0] exp_a;
    clk        = 1'b0;
    rst        = 1'b1;
    start      = 1'b0;
    plaintext  = '0;
    key        = '0;
    rom_data   = 8'h00;
    lfsr_state = 16'd7683;
    fill_sbox();
    repeat (2) next_cycle();
    rst = 1'b0;
    check_value("reset done", 128'd0, {127'd0, done});
    check_value("reset ciphertext", 128'd0, ciphertext);
    check_value("reset rom address", 128'd0, {120'd0, rom_addr});

    pt = 128'h00112233445566778899aabbccddeeff;
    k  = 128'h000102030405060708090a0b0c0d0e0f;
    check_value("fips model", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, encrypt_block(pt, k));
    run_block("fips vector", pt, k);

    for (int i = 0; i < 40; i++) begin
      random_block(pt);
      random_block(k);
      run_block($sformatf("random %0d", i), pt, k);
    end

    // start and input changes while busy must be ignored
    random_block(pt);
    random_block(k);
    exp_a = encrypt_block(pt, k);
    start_block(pt, k);
    repeat (20) next_cycle();
    for (int i = 0; i < 6; i++) begin
      random_block(plaintext);
      random_block(key);
      start = ~start;
      next_cycle();
    end
    start = 1'b0;
    wait_done("busy start");
    check_value("busy start", exp_a, ciphertext);

    // result holds while idle and back to back starts follow
    for (int i = 0; i < 20; i++) begin
      next_cycle();
      check_value("idle hold", exp_a, ciphertext);
      check_value("idle done", 128'd0, {127'd0, done});
    end
    random_block(pt);
    random_block(k);
    start_block(pt, k);
    wait_done("back to back first");
    check_value("back to back first", encrypt_block(pt, k), ciphertext);
    random_block(pt);
    random_block(k);
    start_block(pt, k);
    wait_done("back to back second");
    check_value("back to back second", encrypt_block(pt, k), ciphertext);
    next_cycle();

    // reset in the middle of a block
    random_block(pt);
    random_block(k);
    start_block(pt, k);
    repeat (100) next_cycle();
    rst = 1'b1;
    repeat (2) next_cycle();
    rst = 1'b0;
    for (int i = 0; i < 300; i++) begin
      check_value("aborted block done", 128'd0, {127'd0, done});
      next_cycle();
    end
    random_block(pt);
    random_block(k);
    run_block("after reset", pt, k);

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+sim
verilog/aes_pkg.sv
verilog/aes_ctrl_if.sv
verilog/aes_ctrl_fsm.sv
verilog/aes_step_counter.sv
verilog/aes_sbox_lookup.sv
verilog/aes_key_expand.sv
verilog/aes_state_path.sv
verilog/aes_core.sv
sim/tb_aes_core.sv

//--- Bender.yml
package:
  name: aes_core

sources:
  - files:
      - verilog/aes_pkg.sv
      - verilog/aes_ctrl_if.sv
      - verilog/aes_ctrl_fsm.sv
      - verilog/aes_step_counter.sv
      - verilog/aes_sbox_lookup.sv
      - verilog/aes_key_expand.sv
      - verilog/aes_state_path.sv
      - verilog/aes_core.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_aes_core.sv
